/* logic/clr_prng_pkg.sv */
`default_nettype none

// Shared constants for the register-clearing PRNG.
// The RTL and the testbench reference model both draw on these definitions.
package clr_prng_pkg;

  // The generator exists only at this width.
  localparam int unsigned PrngWidth = 64;

  // Share 0 comes from the S-box layer and share 1 is a reordering of it.
  localparam int unsigned NumShares = 2;

  // One word of seed, LFSR state or share data.
  typedef logic [PrngWidth-1:0] prng_word_t;

  // Galois feedback mask for x^64 + x^63 + x^61 + x^60 + 1.
  // The state shifts right, so polynomial term k lands on bit k-1.
  localparam prng_word_t LfsrTaps = 64'hD800_0000_0000_0000;

  // Reset value of the LFSR state.
  // It must be nonzero, because the all-zero state never leaves itself.
  localparam prng_word_t DefaultLfsrSeed = 64'h3A5C_9E17_D24B_6F81;

  // Output bit i of a permutation layer takes input bit StatePerm[i].
  // The same table is applied before and after the S-box layer.
  // Entries follow (29*i + 11) mod 64, which visits every position once.
  localparam logic [5:0] StatePerm [PrngWidth] = '{
    6'd11, 6'd40, 6'd5,  6'd34, 6'd63, 6'd28, 6'd57, 6'd22,
    6'd51, 6'd16, 6'd45, 6'd10, 6'd39, 6'd4,  6'd33, 6'd62,
    6'd27, 6'd56, 6'd21, 6'd50, 6'd15, 6'd44, 6'd9,  6'd38,
    6'd3,  6'd32, 6'd61, 6'd26, 6'd55, 6'd20, 6'd49, 6'd14,
    6'd43, 6'd8,  6'd37, 6'd2,  6'd31, 6'd60, 6'd25, 6'd54,
    6'd19, 6'd48, 6'd13, 6'd42, 6'd7,  6'd36, 6'd1,  6'd30,
    6'd59, 6'd24, 6'd53, 6'd18, 6'd47, 6'd12, 6'd41, 6'd6,
    6'd35, 6'd0,  6'd29, 6'd58, 6'd23, 6'd52, 6'd17, 6'd46
  };

  // Share 1 bit i takes share 0 bit SharePerm[i].
  // Entries follow (37*i + 5) mod 64.
  localparam logic [5:0] SharePerm [PrngWidth] = '{
    6'd5,  6'd42, 6'd15, 6'd52, 6'd25, 6'd62, 6'd35, 6'd8,
    6'd45, 6'd18, 6'd55, 6'd28, 6'd1,  6'd38, 6'd11, 6'd48,
    6'd21, 6'd58, 6'd31, 6'd4,  6'd41, 6'd14, 6'd51, 6'd24,
    6'd61, 6'd34, 6'd7,  6'd44, 6'd17, 6'd54, 6'd27, 6'd0,
    6'd37, 6'd10, 6'd47, 6'd20, 6'd57, 6'd30, 6'd3,  6'd40,
    6'd13, 6'd50, 6'd23, 6'd60, 6'd33, 6'd6,  6'd43, 6'd16,
    6'd53, 6'd26, 6'd63, 6'd36, 6'd9,  6'd46, 6'd19, 6'd56,
    6'd29, 6'd2,  6'd39, 6'd12, 6'd49, 6'd22, 6'd59, 6'd32
  };

  // PRINCE S-box, indexed by the input nibble.
  localparam logic [3:0] PrinceSbox [16] = '{
    4'hB, 4'hF, 4'h3, 4'h2, 4'hA, 4'hC, 4'h9, 4'h1,
    4'h6, 4'h7, 4'h8, 4'h0, 4'hE, 4'h5, 4'hD, 4'h4
  };

endpackage

`default_nettype wire

/* logic/clr_prng_reseed.sv */
`timescale 1ns/1ps
`default_nettype none

// Collects entropy words for a reseed and presents the assembled 64-bit seed.
// The seed and its valid strobe are combinational on the cycle of the last word.
module clr_prng_reseed #(
  parameter int unsigned EntropyWidth = 32
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       reseed_req_i,
  input  logic                       entropy_ack_i,
  input  logic [EntropyWidth-1:0]    entropy_i,
  output logic                       entropy_req_o,
  output logic                       reseed_ack_o,
  output clr_prng_pkg::prng_word_t   seed_o,
  output logic                       seed_valid_o
);

  import clr_prng_pkg::*;

  // A word is consumed on every cycle where request and acknowledge meet.
  logic entropy_fire;

  // Entropy is requested for as long as the reseed is pending.
  // The requester drops reseed_req_i once it sees the acknowledge.
  assign entropy_req_o = reseed_req_i;
  assign entropy_fire  = entropy_req_o & entropy_ack_i;

  // The reseed completes on the very cycle the seed is handed over.
  assign reseed_ack_o = seed_valid_o;

  if (EntropyWidth == PrngWidth / 2) begin : gen_buffer
    // Two words make a seed, so a single buffered word is enough.
    logic [EntropyWidth-1:0] buffer_q;
    logic                    buffer_valid_q;

    // The flag toggles with each accepted word.
    // A withdrawn request throws away a half-collected seed.
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        buffer_valid_q <= 1'b0;
      end else if (!reseed_req_i) begin
        buffer_valid_q <= 1'b0;
      end else if (entropy_fire) begin
        buffer_valid_q <= ~buffer_valid_q;
      end
    end

    // Only the first word of a pair is stored.
    always_ff @(posedge clk_i) begin
      if (entropy_fire && !buffer_valid_q) begin
        buffer_q <= entropy_i;
      end
    end

    // The second word goes on top of the buffered low half.
    assign seed_o       = {entropy_i, buffer_q};
    assign seed_valid_o = buffer_valid_q & entropy_fire;

  end else begin : gen_packer
    // Narrow words are shifted in from the top, so the first word ends up lowest.
    localparam int unsigned NumWords = PrngWidth / EntropyWidth;
    localparam int unsigned CntWidth = (NumWords > 1) ? $clog2(NumWords) : 1;

    prng_word_t          pack_q;
    prng_word_t          pack_d;
    logic [CntWidth-1:0] word_cnt_q;
    logic                last_word;

    assign pack_d    = {entropy_i, pack_q[PrngWidth-1:EntropyWidth]};
    assign last_word = (word_cnt_q == CntWidth'(NumWords - 1));

    // The counter restarts after a complete seed or an abandoned reseed.
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        word_cnt_q <= '0;
      end else if (!reseed_req_i || seed_valid_o) begin
        word_cnt_q <= '0;
      end else if (entropy_fire) begin
        word_cnt_q <= word_cnt_q + 1'b1;
      end
    end

    always_ff @(posedge clk_i) begin
      if (entropy_fire) begin
        pack_q <= pack_d;
      end
    end

    // On the last word the seed is the shift result, without waiting a cycle.
    assign seed_o       = pack_d;
    assign seed_valid_o = entropy_fire & last_word;
  end

  // The word width must split the seed evenly.
  // Widths above one half are not supported.
  initial begin : p_width_check
    assert ((PrngWidth % EntropyWidth == 0) && (EntropyWidth <= PrngWidth / 2))
      else $fatal(1, "EntropyWidth %0d does not divide the seed width", EntropyWidth);
  end

  // A reseed ends with its acknowledge, and the requester then withdraws its request.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    reseed_ack_o |=> !reseed_req_i)
    else $error("Reseed request still held after the reseed acknowledge");

  // The entropy source must not acknowledge a word that was never requested.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    entropy_ack_i |-> entropy_req_o)
    else $error("Entropy acknowledge without an entropy request");

endmodule

`default_nettype wire

/* logic/clr_prng_lfsr.sv */
`timescale 1ns/1ps
`default_nettype none

// Galois LFSR holding the generator state.
// It steps once per data handshake and loads a fresh seed when the reseed unit offers one.
module clr_prng_lfsr (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     data_req_i,
  input  logic                     reseed_req_i,
  input  clr_prng_pkg::prng_word_t seed_i,
  input  logic                     seed_valid_i,
  output logic                     data_ack_o,
  output clr_prng_pkg::prng_word_t state_o
);

  import clr_prng_pkg::*;

  prng_word_t state_q;
  prng_word_t state_d;
  prng_word_t step_value;
  logic       lfsr_en;

  // Reseeding wins over data.
  // While a reseed is pending no data request is acknowledged, so consumers stall.
  assign data_ack_o = reseed_req_i ? 1'b0 : data_req_i;

  // The state advances only when a consumer actually takes the shares.
  assign lfsr_en = data_req_i & data_ack_o;

  // Right shift by one.
  // The bit falling out of position 0 decides whether the taps are folded back in.
  assign step_value = state_q[0] ? ((state_q >> 1) ^ LfsrTaps) : (state_q >> 1);

  // A seed load overrides a step in the same cycle.
  // Otherwise the state holds while no handshake takes place.
  always_comb begin
    state_d = state_q;
    if (seed_valid_i) begin
      state_d = seed_i;
    end else if (lfsr_en) begin
      state_d = step_value;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DefaultLfsrSeed;
    end else begin
      state_q <= state_d;
    end
  end

  assign state_o = state_q;

  // The all-zero state locks up the LFSR.
  // It can only be reached through a zero seed from the entropy source.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q != '0)
    else $error("LFSR state has collapsed to all zeros");

endmodule

`default_nettype wire

/* logic/clr_prng_output.sv */
`timescale 1ns/1ps
`default_nettype none

// Turns the raw LFSR state into the two wipe shares.
// The path is permutation, PRINCE S-boxes and permutation for share 0.
// A separate bit reordering of share 0 gives share 1.
module clr_prng_output (
  input  clr_prng_pkg::prng_word_t state_i,
  output clr_prng_pkg::prng_word_t share0_o,
  output clr_prng_pkg::prng_word_t share1_o
);

  import clr_prng_pkg::*;

  prng_word_t perm_in;
  prng_word_t sbox_out;
  prng_word_t share0;
  prng_word_t share1;

  // First permutation spreads neighbouring LFSR bits over different S-boxes.
  for (genvar i = 0; i < PrngWidth; i++) begin : gen_perm_in
    assign perm_in[i] = state_i[StatePerm[i]];
  end

  // Sixteen S-boxes work on the nibbles of the permuted state.
  // This is the only nonlinear step in the generator.
  for (genvar n = 0; n < PrngWidth / 4; n++) begin : gen_sbox
    assign sbox_out[4*n +: 4] = PrinceSbox[perm_in[4*n +: 4]];
  end

  // The second pass of the same permutation mixes the S-box outputs.
  for (genvar i = 0; i < PrngWidth; i++) begin : gen_perm_out
    assign share0[i] = sbox_out[StatePerm[i]];
  end

  // Share 1 is share 0 with its bits reordered, so it differs per position.
  for (genvar i = 0; i < PrngWidth; i++) begin : gen_share_perm
    assign share1[i] = share0[SharePerm[i]];
  end

  assign share0_o = share0;
  assign share1_o = share1;

  // Every position must appear exactly once in each table.
  // Otherwise some state bits would never reach the shares.
  initial begin : p_perm_check
    prng_word_t state_cover;
    prng_word_t share_cover;
    state_cover = '0;
    share_cover = '0;
    for (int k = 0; k < PrngWidth; k++) begin
      state_cover[StatePerm[k]] = 1'b1;
      share_cover[SharePerm[k]] = 1'b1;
    end
    assert (&state_cover)
      else $fatal(1, "StatePerm does not cover every bit position");
    assert (&share_cover)
      else $fatal(1, "SharePerm does not cover every bit position");
    // Only two shares are produced here.
    assert (NumShares == 2)
      else $fatal(1, "Output layer supports exactly two shares");
  end

endmodule

`default_nettype wire

/* logic/clr_prng_top.sv */
`timescale 1ns/1ps
`default_nettype none

// Register-clearing PRNG.
// A reseed unit assembles entropy into a seed, the LFSR holds the state,
// and the output layer derives two shares of wipe data from it.
module clr_prng_top #(
  parameter int unsigned EntropyWidth = 32
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // Data consumer side.
  input  logic                     data_req_i,
  output logic                     data_ack_o,
  output clr_prng_pkg::prng_word_t share0_o,
  output clr_prng_pkg::prng_word_t share1_o,

  // Reseed requester side.
  input  logic                     reseed_req_i,
  output logic                     reseed_ack_o,

  // Entropy source side.
  output logic                     entropy_req_o,
  input  logic                     entropy_ack_i,
  input  logic [EntropyWidth-1:0]  entropy_i
);

  import clr_prng_pkg::*;

  prng_word_t seed;
  logic       seed_valid;
  prng_word_t lfsr_state;

  // Seed assembly from the entropy source.
  clr_prng_reseed #(
    .EntropyWidth (EntropyWidth)
  ) clr_prng_reseed_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .reseed_req_i  (reseed_req_i),
    .entropy_ack_i (entropy_ack_i),
    .entropy_i     (entropy_i),
    .entropy_req_o (entropy_req_o),
    .reseed_ack_o  (reseed_ack_o),
    .seed_o        (seed),
    .seed_valid_o  (seed_valid)
  );

  // State register.
  // It also answers data requests, since it knows when a reseed blocks them.
  clr_prng_lfsr clr_prng_lfsr_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .data_req_i   (data_req_i),
    .reseed_req_i (reseed_req_i),
    .seed_i       (seed),
    .seed_valid_i (seed_valid),
    .data_ack_o   (data_ack_o),
    .state_o      (lfsr_state)
  );

  // Shares always reflect the current state, with no extra register stage.
  clr_prng_output clr_prng_output_inst (
    .state_i  (lfsr_state),
    .share0_o (share0_o),
    .share1_o (share1_o)
  );

endmodule

`default_nettype wire

/* verif/clr_prng_tb.sv */
`timescale 1ns/1ps
`default_nettype none

// Testbench for the register-clearing PRNG.
// A reference model tracks the LFSR state and a separate process compares every cycle.
module clr_prng_tb;

  import clr_prng_pkg::*;

  localparam int unsigned EntropyWidth = 32;
  localparam int          NumWords     = PrngWidth / EntropyWidth;
  localparam int unsigned RandSeed     = 43117;
  localparam int          ReqTimeout   = 8;
  // A reseed needs NumWords words, so a few extra words already mean a hang.
  localparam int          WordTimeout  = NumWords + 4;

  logic                    clk_i = 1'b0;
  logic                    rst_ni;
  logic                    data_req_i;
  logic                    data_ack_o;
  prng_word_t              share0_o;
  prng_word_t              share1_o;
  logic                    reseed_req_i;
  logic                    reseed_ack_o;
  logic                    entropy_req_o;
  logic                    entropy_ack_i;
  logic [EntropyWidth-1:0] entropy_i;

  // Model state, expected seed and expected reseed strobe.
  prng_word_t model_state = DefaultLfsrSeed;
  prng_word_t exp_seed;
  logic       exp_reseed_ack;
  logic       exp_data_ack;
  prng_word_t exp_share0;
  logic       check_en;

  int share_errors    = 0;
  int ack_errors      = 0;
  int timeout_errors  = 0;
  int cycles_compared = 0;
  int handshakes      = 0;

  always #5 clk_i = ~clk_i;

  clr_prng_top #(
    .EntropyWidth (EntropyWidth)
  ) clr_prng_top_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .data_req_i    (data_req_i),
    .data_ack_o    (data_ack_o),
    .share0_o      (share0_o),
    .share1_o      (share1_o),
    .reseed_req_i  (reseed_req_i),
    .reseed_ack_o  (reseed_ack_o),
    .entropy_req_o (entropy_req_o),
    .entropy_ack_i (entropy_ack_i),
    .entropy_i     (entropy_i)
  );

  // One Galois step shifts right and folds in the taps when a one drops out.
  function automatic prng_word_t ref_next_state(prng_word_t s);
    prng_word_t n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ LfsrTaps;
    end
    return n;
  endfunction

  // Share 0 is permutation, S-box per nibble, then the same permutation again.
  function automatic prng_word_t ref_share0(prng_word_t s);
    prng_word_t p;
    prng_word_t b;
    prng_word_t r;
    for (int i = 0; i < PrngWidth; i++) begin
      p[i] = s[StatePerm[i]];
    end
    for (int n = 0; n < PrngWidth / 4; n++) begin
      b[4*n +: 4] = PrinceSbox[p[4*n +: 4]];
    end
    for (int i = 0; i < PrngWidth; i++) begin
      r[i] = b[StatePerm[i]];
    end
    return r;
  endfunction

  // Share 1 bit i is share 0 bit SharePerm[i].
  function automatic prng_word_t ref_share1(prng_word_t sh0);
    prng_word_t r;
    for (int i = 0; i < PrngWidth; i++) begin
      r[i] = sh0[SharePerm[i]];
    end
    return r;
  endfunction

  task automatic check_share(input string what, input prng_word_t got, input prng_word_t exp);
    if (got !== exp) begin
      share_errors++;
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_ack(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      ack_errors++;
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Outputs are sampled at the falling edge, well away from the input changes.
  // The model moves to the next cycle's state after the comparison.
  always @(negedge clk_i) begin
    if (check_en) begin
      cycles_compared++;
      exp_data_ack = data_req_i & ~reseed_req_i;
      exp_share0   = ref_share0(model_state);
      check_ack("data_ack_o", data_ack_o, exp_data_ack);
      check_ack("entropy_req_o", entropy_req_o, reseed_req_i);
      check_ack("reseed_ack_o", reseed_ack_o, exp_reseed_ack);
      check_share("share0_o", share0_o, exp_share0);
      check_share("share1_o", share1_o, ref_share1(exp_share0));
      check_share("share1_o against reordered share0_o", share1_o, ref_share1(share0_o));
      // A seed load wins over a step.
      if (exp_reseed_ack) begin
        model_state = exp_seed;
      end else if (exp_data_ack) begin
        model_state = ref_next_state(model_state);
        handshakes++;
      end
    end
  end

  // The consumer request takes a new random level every cycle.
  task automatic run_random_data(input int cycles);
    repeat (cycles) begin
      @(posedge clk_i);
      #1;
      data_req_i = 1'($urandom_range(1, 0));
    end
  endtask

  task automatic wait_entropy_req(output bit ok);
    int cycles;
    ok     = 1'b0;
    cycles = 0;
    while (!ok && cycles < ReqTimeout) begin
      @(negedge clk_i);
      ok = entropy_req_o;
      cycles++;
    end
    if (!ok) begin
      timeout_errors++;
      $display("Timeout: entropy_req_o stayed low for %0d cycles after a reseed request",
               ReqTimeout);
    end
  endtask

  // Hands out words with random gaps until the DUT acknowledges the reseed.
  // Words go in least significant first.
  task automatic feed_entropy(output bit ok);
    int                      words;
    int                      gap;
    logic [EntropyWidth-1:0] word;
    ok    = 1'b0;
    words = 0;
    while (!ok && words < WordTimeout) begin
      gap = int'($urandom_range(3, 0));
      repeat (gap) begin
        @(posedge clk_i);
        #1;
        entropy_ack_i  = 1'b0;
        entropy_i      = EntropyWidth'($urandom);
        exp_reseed_ack = 1'b0;
      end
      @(posedge clk_i);
      #1;
      word          = EntropyWidth'($urandom);
      entropy_ack_i = 1'b1;
      entropy_i     = word;
      if (words < NumWords) begin
        exp_seed[EntropyWidth*words +: EntropyWidth] = word;
      end
      exp_reseed_ack = (words == NumWords - 1);
      @(negedge clk_i);
      ok = reseed_ack_o;
      words++;
    end
    if (!ok) begin
      timeout_errors++;
      $display("Timeout: reseed_ack_o never rose after %0d entropy words", WordTimeout);
    end
  endtask

  // The consumer keeps requesting data the whole time, so acknowledges must stay low.
  task automatic run_reseed(output bit ok);
    @(posedge clk_i);
    #1;
    data_req_i   = 1'b1;
    reseed_req_i = 1'b1;
    exp_seed     = '0;
    wait_entropy_req(ok);
    if (ok) begin
      feed_entropy(ok);
    end
    @(posedge clk_i);
    #1;
    entropy_ack_i  = 1'b0;
    exp_reseed_ack = 1'b0;
    reseed_req_i   = 1'b0;
  endtask

  task automatic finish_run();
    int total;
    total = share_errors + ack_errors + timeout_errors;
    $display("Cycles %0d, handshakes %0d, share errors %0d, ack errors %0d, timeouts %0d",
             cycles_compared, handshakes, share_errors, ack_errors, timeout_errors);
    if (total == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  initial begin : stimulus
    bit ok;
    void'($urandom(RandSeed));
    rst_ni         = 1'b0;
    data_req_i     = 1'b0;
    reseed_req_i   = 1'b0;
    entropy_ack_i  = 1'b0;
    entropy_i      = '0;
    exp_seed       = '0;
    exp_reseed_ack = 1'b0;
    check_en       = 1'b0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_ni   = 1'b1;
    check_en = 1'b1;
    // Idle cycles show the reset state in the shares.
    repeat (4) @(posedge clk_i);
    run_random_data(200);
    ok = 1'b1;
    for (int r = 0; r < 3 && ok; r++) begin
      run_reseed(ok);
      if (ok) begin
        run_random_data(30);
      end
    end
    @(posedge clk_i);
    #1;
    data_req_i = 1'b0;
    repeat (2) @(posedge clk_i);
    finish_run();
  end

endmodule

`default_nettype wire

/* verilog.f */
logic/clr_prng_pkg.sv
logic/clr_prng_reseed.sv
logic/clr_prng_lfsr.sv
logic/clr_prng_output.sv
logic/clr_prng_top.sv
verif/clr_prng_tb.sv

/* Makefile */
# Verilator build and run for the register-clearing PRNG.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= clr_prng_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
JOBS      ?= 4
PASS_MSG  ?= TEST OK

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS JOBS PASS_MSG"

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$($(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation did not pass"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
